//--- src/mbist_pkg.sv
package mbist_pkg;

  //////////////////////////////////////////////////
  // Widths

  // Control counter and the address slice taken from it
  localparam int CTRL_W = 21;
  localparam int ADDR_W = 10;

  // Cache read word widths
  localparam int DC_DATA_W = 72;
  localparam int IC_DATA_W = 68;

  // Cache address fields
  localparam int DC_INDEX_W = 7;
  localparam int IC_INDEX_W = 8;
  localparam int WAY_W      = 2;

  // Write data is one byte, expanded by the cache into a full word
  localparam int PATTERN_W = 8;

  //////////////////////////////////////////////////
  // Timing

  // Stages between the counter end bit and done, covers reads in flight
  localparam int DRAIN_CYCLES = 4;

  // Cycles from a read strobe at the port to its data
  localparam int READ_LATENCY = 1;

  //////////////////////////////////////////////////
  // Encodings

  // March elements
  // Elements 0, 1, 2 and 6 walk upward, the rest walk downward
  // Elements 6 and 7 are read, write, write, read
  typedef enum logic [2:0] {
    ME_INIT  = 3'd0,
    ME_UP_A  = 3'd1,
    ME_UP_B  = 3'd2,
    ME_DN_A  = 3'd3,
    ME_DN_B  = 3'd4,
    ME_DN_C  = 3'd5,
    ME_UP_4C = 3'd6,
    ME_DN_4C = 3'd7
  } march_elem_e;

  // Data backgrounds
  typedef enum logic [1:0] {
    BG_AA = 2'd0,
    BG_99 = 2'd1,
    BG_CC = 2'd2,
    BG_00 = 2'd3
  } data_bg_e;

  //////////////////////////////////////////////////
  // Structs

  // Control counter layout, msb first
  typedef struct packed {
    logic              done_bit;
    logic              icache_sel;
    data_bg_e          bg;
    logic              addr_mix;
    logic              word_sel;
    march_elem_e       elem;
    logic [ADDR_W-1:0] addr;
    logic [1:0]        rw_phase;
  } ctrl_word_t;

  // Data cache request
  typedef struct packed {
    logic                  read;
    logic                  write;
    logic                  word;
    logic [WAY_W-1:0]      way;
    logic [DC_INDEX_W-1:0] index;
  } dc_req_t;

  // Instruction cache request
  typedef struct packed {
    logic                  read;
    logic                  write;
    logic                  word;
    logic [WAY_W-1:0]      way;
    logic [IC_INDEX_W-1:0] index;
  } ic_req_t;

endpackage

//--- src/mbist_march_ctrl.sv
`timescale 1ns/1ps

module mbist_march_ctrl (
  input  logic                  rclk,
  input  logic                  arst_n,
  input  logic                  mbist_start,
  input  logic                  mbist_stop_on_fail,
  input  logic                  dcache_fail,
  input  logic                  icache_fail,
  output mbist_pkg::ctrl_word_t ctrl,
  output logic                  run,
  output logic                  restart,
  output logic                  mbist_done
);

  import mbist_pkg::*;

  // Start sampling
  logic start_q;
  logic start_q2;

  // Mode latched at start
  logic stop_on_fail_q;

  // Control counter
  logic [CTRL_W-1:0] cnt_q;
  logic [CTRL_W-1:0] cnt_d;
  ctrl_word_t        cw_raw;
  ctrl_word_t        cw;
  logic              four_cycle;
  logic [1:0]        step;

  // Completion
  logic                    fail_stop;
  logic                    done_int;
  logic [DRAIN_CYCLES-1:0] drain_q;

  //////////////////////////////////////////////////
  // Start edge and mode latch

  always_ff @(posedge rclk or negedge arst_n) begin
    if (!arst_n) begin
      start_q  <= 1'b0;
      start_q2 <= 1'b0;
    end else begin
      start_q  <= mbist_start;
      start_q2 <= start_q;
    end
  end

  // One cycle after the first high sample of mbist_start
  assign restart = start_q & ~start_q2;

  always_ff @(posedge rclk or negedge arst_n) begin
    if (!arst_n) begin
      stop_on_fail_q <= 1'b0;
    end else if (restart) begin
      stop_on_fail_q <= mbist_stop_on_fail;
    end
  end

  //////////////////////////////////////////////////
  // Control counter

  assign cw_raw = ctrl_word_t'(cnt_q);

  // Data cache only covers the upper half of the address space
  // The forced bit is stored back, so the carry skips the lower half
  always_comb begin
    cw = cw_raw;
    if (!cw_raw.icache_sel) begin
      cw.addr[ADDR_W-1] = 1'b1;
    end
  end

  assign four_cycle = (cw.elem == ME_UP_4C) || (cw.elem == ME_DN_4C);

  // Two-cycle elements skip rw_phase[0]
  assign step = four_cycle ? 2'd1 : 2'd2;

  always_comb begin
    if (restart) begin
      cnt_d = '0;
    end else if (run) begin
      cnt_d = CTRL_W'(cw) + CTRL_W'(step);
    end else begin
      cnt_d = CTRL_W'(cw);
    end
  end

  always_ff @(posedge rclk or negedge arst_n) begin
    if (!arst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  assign ctrl = cw;

  //////////////////////////////////////////////////
  // Run and done

  assign fail_stop = stop_on_fail_q & (dcache_fail | icache_fail);
  assign done_int  = fail_stop | cw.done_bit;

  // Paused while mbist_start is low, finished once done_int is set
  assign run = start_q & start_q2 & ~done_int;

  // Drain so the last reads reach the fail flags before done
  always_ff @(posedge rclk or negedge arst_n) begin
    if (!arst_n) begin
      drain_q <= '0;
    end else if (restart) begin
      drain_q <= '0;
    end else begin
      drain_q <= {drain_q[DRAIN_CYCLES-2:0], cw.done_bit};
    end
  end

  assign mbist_done = fail_stop | drain_q[DRAIN_CYCLES-1];

  //////////////////////////////////////////////////
  // Checks

  // Done only after the counter has stopped stepping
  a_run_not_done: assert property (
    @(posedge rclk) disable iff (!arst_n)
    !(run && mbist_done)
  ) else $error("run and mbist_done high together");

endmodule

//--- src/mbist_pattern_gen.sv
`timescale 1ns/1ps

module mbist_pattern_gen (
  input  logic                             rclk,
  input  logic                             arst_n,
  input  mbist_pkg::ctrl_word_t            ctrl,
  input  logic                             run,
  input  logic                             restart,
  output mbist_pkg::dc_req_t               dc_req,
  output mbist_pkg::ic_req_t               ic_req,
  output logic [mbist_pkg::PATTERN_W-1:0]  wdata
);

  import mbist_pkg::*;

  logic                 up_march;
  logic                 four_cycle;
  logic [ADDR_W-1:0]    addr_dir;
  logic [ADDR_W-1:0]    addr_mixed;
  logic                 write_now;
  logic                 read_now;
  logic                 true_data;
  logic [PATTERN_W-1:0] pattern;
  logic [PATTERN_W-1:0] wdata_d;
  dc_req_t              dc_req_d;
  ic_req_t              ic_req_d;

  //////////////////////////////////////////////////
  // Address

  assign up_march = (ctrl.elem == ME_INIT) || (ctrl.elem == ME_UP_A) ||
                    (ctrl.elem == ME_UP_B) || (ctrl.elem == ME_UP_4C);

  assign addr_dir = up_march ? ctrl.addr : ~ctrl.addr;

  // Mixing rotates the index field differently per cache
  always_comb begin
    if (!ctrl.addr_mix) begin
      addr_mixed = addr_dir;
    end else if (ctrl.icache_sel) begin
      addr_mixed = {addr_dir[9:8], addr_dir[6:0], addr_dir[7]};
    end else begin
      addr_mixed = {addr_dir[9:8], addr_dir[0], addr_dir[7:1]};
    end
  end

  //////////////////////////////////////////////////
  // Strobes and data

  assign four_cycle = (ctrl.elem == ME_UP_4C) || (ctrl.elem == ME_DN_4C);

  assign write_now = run & (four_cycle ? (ctrl.rw_phase[0] ^ ctrl.rw_phase[1])
                                       : ctrl.rw_phase[1]);
  assign read_now  = run & ~write_now & (ctrl.elem != ME_INIT);

  // Polarity flips with the element and with the phase
  assign true_data = ctrl.rw_phase[1] ^ ~ctrl.elem[0];

  always_comb begin
    case (ctrl.bg)
      BG_AA:   pattern = 8'hAA;
      BG_99:   pattern = 8'h99;
      BG_CC:   pattern = 8'hCC;
      default: pattern = 8'h00;
    endcase
  end

  assign wdata_d = true_data ? pattern : ~pattern;

  always_comb begin
    dc_req_d.read  = read_now & ~ctrl.icache_sel;
    dc_req_d.write = write_now & ~ctrl.icache_sel;
    dc_req_d.word  = ctrl.word_sel;
    dc_req_d.way   = addr_mixed[8:7] & {WAY_W{run}};
    dc_req_d.index = addr_mixed[DC_INDEX_W-1:0];

    ic_req_d.read  = read_now & ctrl.icache_sel;
    ic_req_d.write = write_now & ctrl.icache_sel;
    ic_req_d.word  = ctrl.word_sel;
    ic_req_d.way   = addr_mixed[9:8] & {WAY_W{run}};
    ic_req_d.index = addr_mixed[IC_INDEX_W-1:0];
  end

  //////////////////////////////////////////////////
  // Port registers

  always_ff @(posedge rclk or negedge arst_n) begin
    if (!arst_n) begin
      dc_req <= '0;
      ic_req <= '0;
      wdata  <= '0;
    end else if (restart) begin
      dc_req <= '0;
      ic_req <= '0;
      wdata  <= '0;
    end else begin
      dc_req <= dc_req_d;
      ic_req <= ic_req_d;
      wdata  <= wdata_d;
    end
  end

  // One access type per cache and cycle
  a_strobe_excl: assert property (
    @(posedge rclk) disable iff (!arst_n)
    !(dc_req.read && dc_req.write) && !(ic_req.read && ic_req.write)
  ) else $error("read and write strobes high together");

endmodule

//--- src/mbist_result_check.sv
`timescale 1ns/1ps

module mbist_result_check (
  input  logic                             rclk,
  input  logic                             arst_n,
  input  logic                             restart,
  input  mbist_pkg::dc_req_t               dc_req,
  input  mbist_pkg::ic_req_t               ic_req,
  input  logic [mbist_pkg::PATTERN_W-1:0]  wdata,
  input  logic [mbist_pkg::DC_DATA_W-1:0]  dcache_data_in,
  input  logic [mbist_pkg::IC_DATA_W-1:0]  icache_data_in,
  output logic                             dcache_fail,
  output logic                             icache_fail
);

  import mbist_pkg::*;

  // Last stage lines up with the captured read data
  localparam int PIPE_D  = READ_LATENCY + 1;
  localparam int DC_REPS = DC_DATA_W / PATTERN_W;
  localparam int IC_REPS = IC_DATA_W / PATTERN_W;

  // Read strobes and expected bytes in flight
  logic [PIPE_D-1:0]    dc_rd_pipe;
  logic [PIPE_D-1:0]    ic_rd_pipe;
  logic [PATTERN_W-1:0] byte_pipe [PIPE_D];

  // Captured read word and its expectation
  logic [DC_DATA_W-1:0] cap_q;
  logic [PATTERN_W-1:0] exp_byte;
  logic [DC_DATA_W-1:0] dc_expect;
  logic [IC_DATA_W-1:0] ic_expect;
  logic                 dc_sel;
  logic                 ic_sel;
  logic                 dc_mismatch;
  logic                 ic_mismatch;

  //////////////////////////////////////////////////
  // Read pipeline

  always_ff @(posedge rclk or negedge arst_n) begin
    if (!arst_n) begin
      dc_rd_pipe <= '0;
      ic_rd_pipe <= '0;
    end else if (restart) begin
      dc_rd_pipe <= '0;
      ic_rd_pipe <= '0;
    end else begin
      dc_rd_pipe <= {dc_rd_pipe[PIPE_D-2:0], dc_req.read};
      ic_rd_pipe <= {ic_rd_pipe[PIPE_D-2:0], ic_req.read};
    end
  end

  // Byte at the port during a read is the expected byte
  always_ff @(posedge rclk) begin
    byte_pipe[0] <= wdata;
    for (int i = 1; i < PIPE_D; i++) begin
      byte_pipe[i] <= byte_pipe[i-1];
    end
  end

  //////////////////////////////////////////////////
  // Capture

  // Stage that sees the returning data of the read
  assign dc_sel = dc_rd_pipe[READ_LATENCY-1];
  assign ic_sel = ic_rd_pipe[READ_LATENCY-1];

  always_ff @(posedge rclk) begin
    if (dc_sel) begin
      cap_q <= dcache_data_in;
    end else if (ic_sel) begin
      cap_q <= {{(DC_DATA_W-IC_DATA_W){1'b0}}, icache_data_in};
    end
  end

  //////////////////////////////////////////////////
  // Compare

  assign exp_byte = byte_pipe[PIPE_D-1];

  assign dc_expect = {DC_REPS{exp_byte}};

  // Instruction word carries the low nibble on top
  assign ic_expect = {exp_byte[PATTERN_W/2-1:0], {IC_REPS{exp_byte}}};

  assign dc_mismatch = (cap_q != dc_expect);
  assign ic_mismatch = (cap_q[IC_DATA_W-1:0] != ic_expect);

  // Sticky until the next start
  always_ff @(posedge rclk or negedge arst_n) begin
    if (!arst_n) begin
      dcache_fail <= 1'b0;
      icache_fail <= 1'b0;
    end else if (restart) begin
      dcache_fail <= 1'b0;
      icache_fail <= 1'b0;
    end else begin
      if (dc_rd_pipe[PIPE_D-1] && dc_mismatch) begin
        dcache_fail <= 1'b1;
      end
      if (ic_rd_pipe[PIPE_D-1] && ic_mismatch) begin
        icache_fail <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Checks

  a_dc_sticky: assert property (
    @(posedge rclk) disable iff (!arst_n)
    $fell(dcache_fail) |-> $past(restart)
  ) else $error("dcache_fail cleared without restart");

  a_ic_sticky: assert property (
    @(posedge rclk) disable iff (!arst_n)
    $fell(icache_fail) |-> $past(restart)
  ) else $error("icache_fail cleared without restart");

endmodule

//--- src/mbist_engine.sv
`timescale 1ns/1ps

module mbist_engine (
  input  logic                             rclk,
  input  logic                             arst_n,
  input  logic                             mbist_start,
  input  logic                             mbist_stop_on_fail,
  input  logic [mbist_pkg::DC_DATA_W-1:0]  dcache_data_in,
  input  logic [mbist_pkg::IC_DATA_W-1:0]  icache_data_in,
  output mbist_pkg::dc_req_t               dcache_req,
  output mbist_pkg::ic_req_t               icache_req,
  output logic [mbist_pkg::PATTERN_W-1:0]  wdata,
  output logic                             mbist_run,
  output logic                             mbist_done,
  output logic                             dcache_fail,
  output logic                             icache_fail
);

  import mbist_pkg::*;

  ctrl_word_t ctrl;
  logic       restart;

  // Sequencing
  mbist_march_ctrl u_march_ctrl (
    .rclk               (rclk),
    .arst_n             (arst_n),
    .mbist_start        (mbist_start),
    .mbist_stop_on_fail (mbist_stop_on_fail),
    .dcache_fail        (dcache_fail),
    .icache_fail        (icache_fail),
    .ctrl               (ctrl),
    .run                (mbist_run),
    .restart            (restart),
    .mbist_done         (mbist_done)
  );

  // Cache requests
  mbist_pattern_gen u_pattern_gen (
    .rclk    (rclk),
    .arst_n  (arst_n),
    .ctrl    (ctrl),
    .run     (mbist_run),
    .restart (restart),
    .dc_req  (dcache_req),
    .ic_req  (icache_req),
    .wdata   (wdata)
  );

  // Read data checking
  mbist_result_check u_result_check (
    .rclk           (rclk),
    .arst_n         (arst_n),
    .restart        (restart),
    .dc_req         (dcache_req),
    .ic_req         (icache_req),
    .wdata          (wdata),
    .dcache_data_in (dcache_data_in),
    .icache_data_in (icache_data_in),
    .dcache_fail    (dcache_fail),
    .icache_fail    (icache_fail)
  );

endmodule

//--- tests/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real PERIOD_NS = 100.0
) (
  output logic rclk
);

  // Free running, starts low
  initial begin
    rclk = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0) rclk = ~rclk;
    end
  end

endmodule

//--- tests/cache_model.sv
`timescale 1ns/1ps

module cache_model #(
  parameter int DATA_W = 72,
  parameter int LOC_W  = 10
) (
  input  logic                          rclk,
  input  logic                          read,
  input  logic                          write,
  input  logic [LOC_W-1:0]              loc,
  input  logic [mbist_pkg::PATTERN_W-1:0] wdata,
  input  logic                          fault_en,
  input  logic [LOC_W-1:0]              fault_loc,
  input  logic [6:0]                    fault_bit,
  input  logic                          fault_val,
  output logic [DATA_W-1:0]             rdata
);

  import mbist_pkg::*;

  // One stored byte per location
  logic [PATTERN_W-1:0] mem [2**LOC_W];

  // Read words in flight
  logic [DATA_W-1:0] rd_pipe [READ_LATENCY];

  // Byte repeated from bit 0 upward, a partial copy lands on top
  function automatic logic [DATA_W-1:0] expand(input logic [PATTERN_W-1:0] b);
    logic [DATA_W-1:0] w;
    for (int i = 0; i < DATA_W; i++) begin
      w[i] = b[i % PATTERN_W];
    end
    return w;
  endfunction

  // Stuck bit on the faulty location
  function automatic logic [DATA_W-1:0] inject(input logic [DATA_W-1:0] w, input logic hit);
    logic [DATA_W-1:0] r;
    r = w;
    if (hit) begin
      r[fault_bit] = fault_val;
    end
    return r;
  endfunction

  always @(posedge rclk) begin
    if (write) begin
      mem[loc] <= wdata;
    end
    if (read) begin
      rd_pipe[0] <= inject(expand(mem[loc]), fault_en && (loc == fault_loc));
    end
    for (int i = 1; i < READ_LATENCY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign rdata = rd_pipe[READ_LATENCY-1];

endmodule

//--- tests/mbist_tb.sv
`timescale 1ns/1ps

module mbist_tb;

  import mbist_pkg::*;

  localparam int unsigned SEED = 32'h886e_6453;

  // Location is word, way and index
  localparam int DC_LOC_W = 1 + WAY_W + DC_INDEX_W;
  localparam int IC_LOC_W = 1 + WAY_W + IC_INDEX_W;

  // Six two-cycle and two four-cycle elements, init writes only
  localparam int ADDR_CYCLES    = 6 * 2 + 2 * 4;
  localparam int READS_PER_ADDR = 5 + 2 * 2;
  // Word halves, mixing on and off, four backgrounds
  localparam int BLOCKS         = 2 * 2 * 4;
  localparam int DC_ADDRS       = 2 ** (ADDR_W - 1);
  localparam int IC_ADDRS       = 2 ** ADDR_W;
  localparam int RUN_CYCLES     = BLOCKS * ADDR_CYCLES * (DC_ADDRS + IC_ADDRS) + DRAIN_CYCLES;
  localparam int TIMEOUT_CYCLES = 5 * RUN_CYCLES;

  typedef struct packed {
    logic                en;
    logic [IC_LOC_W-1:0] loc;
    logic [6:0]          bit_idx;
    logic                val;
  } fault_t;

  logic                 rclk;
  logic                 arst_n;
  logic                 mbist_start;
  logic                 mbist_stop_on_fail;
  logic [DC_DATA_W-1:0] dcache_data_in;
  logic [IC_DATA_W-1:0] icache_data_in;
  dc_req_t              dcache_req;
  ic_req_t              icache_req;
  logic [PATTERN_W-1:0] wdata;
  logic                 mbist_run;
  logic                 mbist_done;
  logic                 dcache_fail;
  logic                 icache_fail;
  logic [DC_LOC_W-1:0]  dc_loc;
  logic [IC_LOC_W-1:0]  ic_loc;
  fault_t               dc_fault;
  fault_t               ic_fault;

  // Reference state, cleared at each start
  logic                 dc_written [2**DC_LOC_W];
  logic                 ic_written [2**IC_LOC_W];
  logic [PATTERN_W-1:0] dc_shadow  [2**DC_LOC_W];
  logic [PATTERN_W-1:0] ic_shadow  [2**IC_LOC_W];
  logic                 dc_fail_pred;
  logic                 ic_fail_pred;
  int                   dc_reads;
  int                   ic_reads;
  logic                 run_prev     = 1'b0;
  int                   cycle_cnt    = 0;
  int                   errors       = 0;
  int                   tests_run    = 0;
  int                   tests_failed = 0;

  tb_clk_gen #(.PERIOD_NS(100.0)) u_clk_gen (.rclk(rclk));

  mbist_engine u_dut (
    .rclk               (rclk),
    .arst_n             (arst_n),
    .mbist_start        (mbist_start),
    .mbist_stop_on_fail (mbist_stop_on_fail),
    .dcache_data_in     (dcache_data_in),
    .icache_data_in     (icache_data_in),
    .dcache_req         (dcache_req),
    .icache_req         (icache_req),
    .wdata              (wdata),
    .mbist_run          (mbist_run),
    .mbist_done         (mbist_done),
    .dcache_fail        (dcache_fail),
    .icache_fail        (icache_fail)
  );

  assign dc_loc = {dcache_req.word, dcache_req.way, dcache_req.index};
  assign ic_loc = {icache_req.word, icache_req.way, icache_req.index};

  cache_model #(.DATA_W(DC_DATA_W), .LOC_W(DC_LOC_W)) u_dcache (
    .rclk      (rclk),
    .read      (dcache_req.read),
    .write     (dcache_req.write),
    .loc       (dc_loc),
    .wdata     (wdata),
    .fault_en  (dc_fault.en),
    .fault_loc (dc_fault.loc[DC_LOC_W-1:0]),
    .fault_bit (dc_fault.bit_idx),
    .fault_val (dc_fault.val),
    .rdata     (dcache_data_in)
  );

  cache_model #(.DATA_W(IC_DATA_W), .LOC_W(IC_LOC_W)) u_icache (
    .rclk      (rclk),
    .read      (icache_req.read),
    .write     (icache_req.write),
    .loc       (ic_loc),
    .wdata     (wdata),
    .fault_en  (ic_fault.en),
    .fault_loc (ic_fault.loc),
    .fault_bit (ic_fault.bit_idx),
    .fault_val (ic_fault.val),
    .rdata     (icache_data_in)
  );

  //////////////////////////////////////////////////
  // Helpers

  function automatic logic any_strobe();
    return dcache_req.read | dcache_req.write | icache_req.read | icache_req.write;
  endfunction

  // Word bit i holds byte bit i mod 8 in both caches
  function automatic logic exposes(input logic [PATTERN_W-1:0] b, input fault_t f);
    return b[f.bit_idx % PATTERN_W] != f.val;
  endfunction

  // Written bytes are one of the four backgrounds or an inverse
  function automatic logic is_background(input logic [PATTERN_W-1:0] b);
    logic [PATTERN_W-1:0] t;
    t = b[7] ? ~b : b;
    return (t == 8'h55) || (t == 8'h66) || (t == 8'h33) || (t == 8'h00);
  endfunction

  function automatic fault_t pick_fault(input int locs, input int width);
    fault_t f;
    f.en      = 1'b1;
    f.loc     = $urandom % locs;
    f.bit_idx = $urandom % width;
    f.val     = $urandom % 2;
    return f;
  endfunction

  task automatic check_value(input string name, input logic [DC_DATA_W-1:0] actual,
                             input logic [DC_DATA_W-1:0] expected);
    assert (actual === expected) else begin
      $display("[FAIL] %0t %s: got %0h, expected %0h", $time, name, actual, expected);
      errors++;
    end
  endtask

  task automatic clear_model();
    for (int i = 0; i < 2 ** IC_LOC_W; i++) begin
      ic_written[i] = 1'b0;
      if (i < 2 ** DC_LOC_W) begin
        dc_written[i] = 1'b0;
      end
    end
    dc_fail_pred = 1'b0;
    ic_fail_pred = 1'b0;
    dc_reads     = 0;
    ic_reads     = 0;
  endtask

  // Low then high on start, returns once restart has cleared the flags
  task automatic start_run(input logic stop_on_fail);
    mbist_start = 1'b0;
    repeat (2) @(negedge rclk);
    clear_model();
    mbist_stop_on_fail = stop_on_fail;
    mbist_start        = 1'b1;
    repeat (2) @(negedge rclk);
  endtask

  task automatic wait_done();
    while (!mbist_done) begin
      @(negedge rclk);
    end
  endtask

  task automatic end_test(input string name, input int err_start);
    tests_run++;
    if (errors == err_start) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err_start);
    end
  endtask

  //////////////////////////////////////////////////
  // Monitor and watchdog

  always @(negedge rclk) begin
    if (arst_n) begin
      // Strobes follow mbist_run by one cycle
      if (any_strobe()) begin
        assert (run_prev) else begin
          $display("%0t: cache strobe without mbist_run the cycle before", $time);
          errors++;
        end
      end
      if (dcache_req.write || icache_req.write) begin
        assert (is_background(wdata)) else begin
          $display("[FAIL] %0t wdata: got %0h, expected a background or its inverse",
                   $time, wdata);
          errors++;
        end
      end
      if (dcache_req.write) begin
        dc_written[dc_loc] = 1'b1;
        dc_shadow[dc_loc]  = wdata;
      end
      if (dcache_req.read) begin
        dc_reads++;
        assert (dc_written[dc_loc]) else begin
          $display("%0t: data cache read of unwritten location %0h", $time, dc_loc);
          errors++;
        end
        if (dc_fault.en && dc_loc == dc_fault.loc && exposes(dc_shadow[dc_loc], dc_fault)) begin
          dc_fail_pred = 1'b1;
        end
      end
      if (icache_req.write) begin
        ic_written[ic_loc] = 1'b1;
        ic_shadow[ic_loc]  = wdata;
      end
      if (icache_req.read) begin
        ic_reads++;
        assert (ic_written[ic_loc]) else begin
          $display("%0t: instruction cache read of unwritten location %0h", $time, ic_loc);
          errors++;
        end
        if (ic_fault.en && ic_loc == ic_fault.loc && exposes(ic_shadow[ic_loc], ic_fault)) begin
          ic_fail_pred = 1'b1;
        end
      end
    end
    run_prev = mbist_run;
  end

  always @(posedge rclk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("Timeout, run still busy after %0d cycles", cycle_cnt);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Tests

  initial begin
    int err_start;
    void'($urandom(SEED));
    arst_n             = 1'b0;
    mbist_start        = 1'b0;
    mbist_stop_on_fail = 1'b0;
    dc_fault           = '0;
    ic_fault           = '0;
    clear_model();
    repeat (8) @(negedge rclk);
    arst_n = 1'b1;
    @(negedge rclk);

    err_start = errors;
    check_value("strobes", any_strobe(), 1'b0);
    check_value("mbist_run", mbist_run, 1'b0);
    check_value("mbist_done", mbist_done, 1'b0);
    check_value("dcache_fail", dcache_fail, 1'b0);
    check_value("icache_fail", icache_fail, 1'b0);
    end_test("reset", err_start);

    err_start = errors;
    start_run(1'b0);
    wait_done();
    check_value("dcache_fail", dcache_fail, 1'b0);
    check_value("icache_fail", icache_fail, 1'b0);
    check_value("dcache reads", dc_reads, BLOCKS * DC_ADDRS * READS_PER_ADDR);
    check_value("icache reads", ic_reads, BLOCKS * IC_ADDRS * READS_PER_ADDR);
    end_test("fault_free", err_start);

    err_start = errors;
    dc_fault = pick_fault(2 ** DC_LOC_W, DC_DATA_W);
    start_run(1'b0);
    wait_done();
    check_value("dc_fail_pred", dc_fail_pred, 1'b1);
    check_value("dcache_fail", dcache_fail, dc_fail_pred);
    check_value("icache_fail", icache_fail, 1'b0);
    end_test("dcache_fault", err_start);

    err_start = errors;
    dc_fault = '0;
    ic_fault = pick_fault(2 ** IC_LOC_W, IC_DATA_W);
    start_run(1'b0);
    wait_done();
    check_value("ic_fail_pred", ic_fail_pred, 1'b1);
    check_value("dcache_fail", dcache_fail, 1'b0);
    check_value("icache_fail", icache_fail, ic_fail_pred);
    end_test("icache_fault", err_start);

    // Done and the flag rise together, strobes stop a cycle later
    err_start = errors;
    ic_fault = '0;
    dc_fault = pick_fault(2 ** DC_LOC_W, DC_DATA_W);
    start_run(1'b1);
    while (!dcache_fail && !mbist_done) begin
      @(negedge rclk);
    end
    check_value("mbist_done", mbist_done, 1'b1);
    check_value("dcache_fail", dcache_fail, dc_fail_pred);
    check_value("icache_fail", icache_fail, 1'b0);
    for (int k = 1; k <= 20; k++) begin
      @(negedge rclk);
      check_value("strobes", any_strobe(), 1'b0);
    end
    end_test("stop_on_fail", err_start);

    err_start = errors;
    dc_fault = pick_fault(2 ** DC_LOC_W, DC_DATA_W);
    start_run(1'b0);
    while (!dcache_fail && !mbist_done) begin
      @(negedge rclk);
    end
    check_value("dcache_fail", dcache_fail, dc_fail_pred);
    mbist_start = 1'b0;
    for (int k = 1; k <= 20; k++) begin
      @(negedge rclk);
      check_value("mbist_run", mbist_run, 1'b0);
      check_value("dcache_fail", dcache_fail, 1'b1);
      check_value("mbist_done", mbist_done, 1'b0);
      if (k >= 2) begin
        check_value("strobes", any_strobe(), 1'b0);
      end
    end
    end_test("pause", err_start);

    err_start = errors;
    dc_fault.en = 1'b0;
    start_run(1'b0);
    check_value("dcache_fail", dcache_fail, 1'b0);
    check_value("icache_fail", icache_fail, 1'b0);
    wait_done();
    check_value("dcache_fail", dcache_fail, 1'b0);
    check_value("icache_fail", icache_fail, 1'b0);
    check_value("dcache reads", dc_reads, BLOCKS * DC_ADDRS * READS_PER_ADDR);
    check_value("icache reads", ic_reads, BLOCKS * IC_ADDRS * READS_PER_ADDR);
    end_test("restart", err_start);

    $display("Tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- src.f
src/mbist_pkg.sv
src/mbist_march_ctrl.sv
src/mbist_pattern_gen.sv
src/mbist_result_check.sv
src/mbist_engine.sv
tests/tb_clk_gen.sv
tests/cache_model.sv
tests/mbist_tb.sv
